// File: dv/tmu_tb_tests.svh
// texture mapping unit directed tests

	task automatic csr_write(input logic [3:0] idx, input logic [31:0] data);
		csr_a_i = {tmu_pkg::CSR_SEL, 6'd0, idx};
		csr_di_i = data;
		csr_we_i = 1'b1;
		@(negedge sys_clk);
		csr_we_i = 1'b0;
	endtask

	task automatic csr_read(input logic [3:0] idx, output logic [31:0] data);
		csr_a_i = {tmu_pkg::CSR_SEL, 6'd0, idx};
		@(negedge sys_clk);
		data = csr_do_o;                         // registered read
	endtask

	task automatic readback(input logic [3:0] idx, input int width);
		logic [31:0] v;
		csr_write(idx, 32'hFFFF_FFFF);
		csr_read(idx, v);
		check($sformatf("reg %0d readback", idx), (64'd1 << width) - 1, v);
	endtask

	// whole texel index after mask and clamp
	function automatic int texel_index(input logic [17:0] c, input logic [17:0] mask,
			input int res);
		int v;
		v = $signed(c & mask);
		v = v >>> 6;
		if (v < 0)
			return 0;
		return (v >= res) ? res - 1 : v;
	endfunction

	function automatic logic [15:0] scale_pixel(input logic [15:0] p, input int br);
		int r, g, b;
		r = p[15:11] * (br + 1) / 64;
		g = p[10:5] * (br + 1) / 64;
		b = p[4:0] * (br + 1) / 64;
		return {5'(r), 6'(g), 5'(b)};
	endfunction

	task automatic plot(input int dx, input int dy, input int tx, input int ty, input bit last);
		tmu_pkg::point_t p;
		logic [15:0] t;
		bit done;
		p = '{12'(dx), 12'(dy), 18'(tx), 18'(ty), last};
		if (dx >= 0 && dy >= 0 && dx < DST_W && dy < DST_H) begin
			t = texel_at(TEX_FB + texel_index(p.ty, m_vmask, TEX_H) * TEX_W
				+ texel_index(p.tx, m_hmask, TEX_W));
			if (!(m_ken && t == m_key))
				exp_pix[DST_FB + dy * DST_W + dx] = scale_pixel(t, m_bright);  // later wins
		end
		point_i = p;
		point_stb_i = 1'b1;
		done = 1'b0;
		while (!done) begin
			done = point_ack_o;                  // settled since the last rising edge
			@(negedge sys_clk);
		end
		point_stb_i = 1'b0;
	endtask

	task automatic setup_regs(input int bright, input logic [15:0] key,
			input logic [17:0] hmask, input logic [17:0] vmask);
		m_bright = bright;
		m_key = key;
		m_hmask = hmask;
		m_vmask = vmask;
		csr_write(tmu_pkg::REG_BRIGHT, bright);
		csr_write(tmu_pkg::REG_CKEY, key);
		csr_write(tmu_pkg::REG_TEXFB, TEX_FB);
		csr_write(tmu_pkg::REG_TEXHRES, TEX_W);
		csr_write(tmu_pkg::REG_TEXVRES, TEX_H);
		csr_write(tmu_pkg::REG_TEXHMASK, hmask);
		csr_write(tmu_pkg::REG_TEXVMASK, vmask);
		csr_write(tmu_pkg::REG_DSTFB, DST_FB);
		csr_write(tmu_pkg::REG_DSTHRES, DST_W);
		csr_write(tmu_pkg::REG_DSTVRES, DST_H);
	endtask

	task automatic start_job(input bit ken);
		m_ken = ken;
		irq_base = irq_count;
		csr_write(tmu_pkg::REG_CTL, {30'd0, ken, 1'b1});
	endtask

	task automatic end_job();
		logic [31:0] ctl;
		while (irq_count == irq_base)
			@(negedge sys_clk);
		repeat (10) @(negedge sys_clk);
		check("irq pulses", 1, irq_count - irq_base);
		csr_read(tmu_pkg::REG_CTL, ctl);
		check("busy after irq", 0, ctl[0]);
		foreach (touched[w])
			check($sformatf("pixel %h", w),
				exp_pix.exists(w) ? exp_pix[w] : lane_of(fill_word(w >> 2), w), fb_pixel(w));
		foreach (exp_pix[w])
			check($sformatf("pixel %h", w), exp_pix[w], fb_pixel(w));
	endtask

	// ************************************************************
	// tests
	// ************************************************************
	task automatic registers_reset();
		logic [31:0] v;
		test_name = "registers_reset";
		check("irq after reset", 0, irq_o);
		csr_read(tmu_pkg::REG_CTL, v);
		check("ctl after reset", 0, v);
		csr_write(tmu_pkg::REG_CTL, 32'hFFFF_FFFE);  // all but start
		csr_read(tmu_pkg::REG_CTL, v);
		check("ctl readback", 32'h2, v);
		readback(tmu_pkg::REG_BRIGHT, 6);
		readback(tmu_pkg::REG_CKEY, 16);
		readback(tmu_pkg::REG_TEXFB, tmu_pkg::FML_DEPTH - 1);
		readback(tmu_pkg::REG_TEXHRES, 11);
		readback(tmu_pkg::REG_TEXVRES, 11);
		readback(tmu_pkg::REG_TEXHMASK, 18);
		readback(tmu_pkg::REG_TEXVMASK, 18);
		readback(tmu_pkg::REG_DSTFB, tmu_pkg::FML_DEPTH - 1);
		readback(tmu_pkg::REG_DSTHRES, 11);
		readback(tmu_pkg::REG_DSTVRES, 11);
	endtask

	task automatic plain_copy();
		logic [31:0] v;
		test_name = "plain_copy";
		setup_regs(63, 16'h0000, 18'h3FFFF, 18'h3FFFF);
		start_job(1'b0);
		csr_write(tmu_pkg::REG_BRIGHT, 0);        // job running, must not land
		plot(0, 0, 0, 0, 1'b0);
		plot(5, 3, 7 * 64 + 32, 2 * 64 + 16, 1'b0);
		plot(13, 7, 20 * 64, 9 * 64 + 63, 1'b0);
		plot(63, 31, 31 * 64, 15 * 64, 1'b1);
		end_job();
		csr_read(tmu_pkg::REG_BRIGHT, v);
		check("bright kept while busy", 63, v);
	endtask

	task automatic decay_and_key();
		logic [15:0] key;
		key = texel_at(TEX_FB + 2 * TEX_W + 3);
		test_name = "decay_and_key";
		setup_regs(31, key, 18'h3FFFF, 18'h3FFFF);
		start_job(1'b1);
		plot(0, 10, 10 * 64, 4 * 64, 1'b0);
		plot(1, 10, 3 * 64 + 40, 2 * 64 + 5, 1'b0);  // texel (3,2) hits the key
		plot(9, 10, 17 * 64, 11 * 64, 1'b1);
		end_job();
		start_job(1'b0);
		plot(1, 10, 3 * 64, 2 * 64, 1'b1);
		end_job();
	endtask

	task automatic mask_clamp_filter();
		test_name = "mask_clamp_filter";
		setup_regs(63, 16'h0000, 18'h007C0, 18'h3FFFF);  // column modulo 32, no fraction
		start_job(1'b0);
		plot(20, 20, 37 * 64 + 32, 5 * 64, 1'b0);
		plot(24, 20, 6 * 64, -3 * 64, 1'b0);
		plot(28, 20, 9 * 64, 40 * 64, 1'b0);
		plot(-1, 5, 0, 0, 1'b0);
		plot(64, 5, 0, 0, 1'b0);
		plot(5, 32, 0, 0, 1'b1);                 // off screen and last
		end_job();
	endtask

	task automatic merge_and_backpressure();
		int writes, dx, dy, tx, ty;
		test_name = "merge_and_backpressure";
		setup_regs(63, 16'h0000, 18'h3FFFF, 18'h3FFFF);
		start_job(1'b0);
		writes = write_count;
		for (int i = 0; i < 4; i++)
			plot(8 + i, 0, (i + 1) * 64, 64, i == 3);
		end_job();
		check("merged writes", 1, write_count - writes);
		check("merged sel", 8'hFF, last_sel);
		setup_regs(47, 16'h0000, 18'h3FFFF, 18'h3FFFF);
		start_job(1'b0);
		for (int i = 0; i < 48; i++) begin
			pt_rng = xorshift(pt_rng);
			dx = int'(pt_rng % 12) - 2;
			dy = int'(pt_rng[15:8] % 4);
			pt_rng = xorshift(pt_rng);
			tx = int'(pt_rng[15:0] % 3000) - 500;
			ty = int'(pt_rng[31:16] % 1500) - 300;
			plot(dx, dy, tx, ty, i == 47);
		end
		end_job();
	endtask

// File: dv/tmu_tb.sv
// texture mapping unit testbench
`timescale 1ns/100ps

module tmu_tb;

	localparam int TEX_FB = 'h1000;          // 16-bit words
	localparam int TEX_W = 32;
	localparam int TEX_H = 16;
	localparam int DST_FB = 'h4000;          // 16-bit words
	localparam int DST_W = 64;
	localparam int DST_H = 32;
	localparam int MAX_CYCLES = 20000;       // about four times the worst case of all tests

	bit sys_clk;
	logic sys_rst;
	logic [13:0] csr_a_i;
	logic csr_we_i;
	logic [31:0] csr_di_i;
	logic [31:0] csr_do_o;
	logic irq_o;
	logic point_stb_i;
	logic point_ack_o;
	tmu_pkg::point_t point_i;
	logic [tmu_pkg::FML_DEPTH-1:0] fmlr_adr_o;
	logic fmlr_stb_o;
	logic fmlr_ack_i;
	logic [63:0] fmlr_di_i;
	logic [tmu_pkg::FML_DEPTH-1:0] fmlw_adr_o;
	logic fmlw_stb_o;
	logic [7:0] fmlw_sel_o;
	logic [63:0] fmlw_do_o;
	logic fmlw_ack_i;

	logic [63:0] fb [int];                   // 64-bit words written so far
	bit touched [int];                       // 16-bit words hit by a sel lane
	logic [15:0] exp_pix [int];
	int errors, checks, cycles, irq_count, irq_base, write_count;
	int rd_wait, wr_wait;
	logic [7:0] last_sel;
	logic [31:0] rd_rng, wr_rng, pt_rng;
	string test_name;
	int m_bright;
	logic [15:0] m_key;
	logic m_ken;
	logic [17:0] m_hmask, m_vmask;

	always #5 sys_clk = ~sys_clk;

	tmu_lite uut (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [15:0] texel_at(input int w);
		return 16'(w) ^ 16'h5A5A;
	endfunction

	// contents of a framebuffer word never written
	function automatic logic [63:0] fill_word(input int q);
		return {~17'(q), 15'h2AAA, 17'(q), 15'h1555};
	endfunction

	function automatic logic [15:0] lane_of(input logic [63:0] d, input int w);
		return d[(3 - w % 4) * 16 +: 16];        // word 00 in bits 63:48
	endfunction

	function automatic logic [15:0] fb_pixel(input int w);
		return lane_of(fb.exists(w >> 2) ? fb[w >> 2] : fill_word(w >> 2), w);
	endfunction

	task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s, %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic store_word(input logic [tmu_pkg::FML_DEPTH-1:0] adr, input logic [7:0] sel,
			input logic [63:0] data);
		int q;
		logic [63:0] d;
		q = adr[tmu_pkg::FML_DEPTH-1:3];
		d = fb.exists(q) ? fb[q] : fill_word(q);
		for (int b = 0; b < 8; b++)
			if (sel[b])
				d[b * 8 +: 8] = data[b * 8 +: 8];
		for (int j = 0; j < 4; j++)
			if (|sel[j * 2 +: 2])
				touched[q * 4 + 3 - j] = 1'b1;
		fb[q] = d;
		write_count++;
		last_sel = sel;
	endtask

	// ************************************************************
	// memory models
	// ************************************************************
	always @(negedge sys_clk) begin
		if (sys_rst) begin
			fmlr_ack_i = 1'b0;
			rd_wait = 0;
		end else if (fmlr_ack_i) begin
			fmlr_ack_i = 1'b0;
		end else if (fmlr_stb_o && rd_wait > 0) begin
			rd_wait--;
		end else if (fmlr_stb_o) begin
			for (int i = 0; i < 4; i++)
				fmlr_di_i[(3 - i) * 16 +: 16] =
					texel_at(int'(fmlr_adr_o[tmu_pkg::FML_DEPTH-1:3]) * 4 + i);
			fmlr_ack_i = 1'b1;
			rd_rng = xorshift(rd_rng);
			rd_wait = int'(rd_rng % 4);
		end
	end

	always @(negedge sys_clk) begin
		if (sys_rst) begin
			fmlw_ack_i = 1'b0;
			wr_wait = 0;
		end else if (fmlw_ack_i) begin
			fmlw_ack_i = 1'b0;
		end else if (fmlw_stb_o && wr_wait > 0) begin
			wr_wait--;
		end else if (fmlw_stb_o) begin
			store_word(fmlw_adr_o, fmlw_sel_o, fmlw_do_o);
			fmlw_ack_i = 1'b1;
			wr_rng = xorshift(wr_rng);
			wr_wait = int'(wr_rng % 4);              // 0 to 3 cycles
		end
	end

	always @(posedge sys_clk) begin
		cycles++;
		if (irq_o)
			irq_count++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("errors: %0d in %0d checks", errors, checks);
			$display("TEST FAIL");
			$finish;
		end
	end

	`include "tmu_tb_tests.svh"

	initial begin
		rd_rng = 32'd78;
		wr_rng = 32'd78;
		pt_rng = 32'd78;
		sys_rst = 1'b1;
		csr_a_i = '0;
		csr_we_i = 1'b0;
		csr_di_i = '0;
		point_stb_i = 1'b0;
		point_i = '0;
		fmlr_ack_i = 1'b0;
		fmlr_di_i = '0;
		fmlw_ack_i = 1'b0;
		repeat (2) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
		registers_reset();
		plain_copy();
		decay_and_key();
		mask_clamp_filter();
		merge_and_backpressure();
		$display("errors: %0d in %0d checks", errors, checks);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: src/tmu_burst.sv
// pixel merge into 64-bit write words
`timescale 1ns/100ps

module tmu_burst (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic flush_i,
	output logic busy_o,
	input  logic pipe_stb_i,
	output logic pipe_ack_o,
	input  tmu_pkg::dpix_t pipe_i,
	output logic pipe_stb_o,
	input  logic pipe_ack_i,
	output tmu_pkg::wword_t pipe_o
);

	logic [tmu_pkg::FML_DEPTH-4:0] open_adr;
	logic [7:0] open_sel;
	logic [63:0] open_data;
	logic [1:0] lane;
	logic [7:0] lane_sel;
	logic same;
	logic accept;

	assign lane = 2'd3 - pipe_i.dst_adr[1:0];
	assign lane_sel = 8'b11 << (lane * 2);
	assign same = pipe_i.dst_adr[tmu_pkg::FML_DEPTH-2:2] == open_adr;

	// a pixel for another word waits until the open one is out
	assign pipe_ack_o = ~pipe_stb_o & (~|open_sel | same);
	assign accept = pipe_stb_i & pipe_ack_o;
	assign busy_o = |open_sel;

	assign pipe_o.adr = open_adr;
	assign pipe_o.sel = open_sel;
	assign pipe_o.data = open_data;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			open_sel <= '0;
			pipe_stb_o <= 1'b0;
		end else if (pipe_stb_o) begin
			if (pipe_ack_i) begin
				pipe_stb_o <= 1'b0;
				open_sel <= '0;
			end
		end else if (accept) begin
			open_sel <= (same ? open_sel : 8'h00) | lane_sel;
		end else if ((pipe_stb_i | flush_i) & |open_sel) begin
			pipe_stb_o <= 1'b1;                 // word change or end of job
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			open_adr <= pipe_i.dst_adr[tmu_pkg::FML_DEPTH-2:2];
			open_data[lane*16 +: 16] <= pipe_i.pix.raw;   // later pixel wins
		end
	end

	sel_nonzero: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o |-> pipe_o.sel != 8'h00);

endmodule

// File: src/tmu_ctlif.sv
// texture mapping unit register block
`timescale 1ns/100ps

module tmu_ctlif (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic [13:0] csr_a_i,
	input  logic csr_we_i,
	input  logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,
	output logic irq_o,
	output logic run_o,
	output tmu_pkg::tmu_cfg_t cfg_o,
	output logic flush_o,
	input  logic last_i,
	input  logic [4:0] busy_i
);

	logic [1:0] state;
	logic csr_hit;
	logic cfg_we;
	logic start;
	logic busy;
	logic pipe_busy;

	assign csr_hit = csr_a_i[13:10] == tmu_pkg::CSR_SEL;
	assign busy = state != tmu_pkg::ST_IDLE;
	assign cfg_we = csr_hit & csr_we_i & ~busy;        // locked during a job
	assign start = cfg_we & (csr_a_i[3:0] == tmu_pkg::REG_CTL) & csr_di_i[0];
	assign run_o = state == tmu_pkg::ST_RUN;
	assign pipe_busy = |(busy_i & tmu_pkg::BUSY_PIPE);
	assign flush_o = (state == tmu_pkg::ST_WAIT_DRAIN) & ~pipe_busy;

	// ************************************************************
	// configuration registers
	// ************************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cfg_o <= '0;
		end else if (cfg_we) begin
			case (csr_a_i[3:0])
				tmu_pkg::REG_CTL:      cfg_o.chroma_en <= csr_di_i[1];
				tmu_pkg::REG_BRIGHT:   cfg_o.brightness <= csr_di_i[5:0];
				tmu_pkg::REG_CKEY:     cfg_o.chroma_key <= csr_di_i[15:0];
				tmu_pkg::REG_TEXFB:    cfg_o.tex_fbuf <= csr_di_i[tmu_pkg::FML_DEPTH-2:0];
				tmu_pkg::REG_TEXHRES:  cfg_o.tex_hres <= csr_di_i[10:0];
				tmu_pkg::REG_TEXVRES:  cfg_o.tex_vres <= csr_di_i[10:0];
				tmu_pkg::REG_TEXHMASK: cfg_o.tex_hmask <= csr_di_i[17:0];
				tmu_pkg::REG_TEXVMASK: cfg_o.tex_vmask <= csr_di_i[17:0];
				tmu_pkg::REG_DSTFB:    cfg_o.dst_fbuf <= csr_di_i[tmu_pkg::FML_DEPTH-2:0];
				tmu_pkg::REG_DSTHRES:  cfg_o.dst_hres <= csr_di_i[10:0];
				tmu_pkg::REG_DSTVRES:  cfg_o.dst_vres <= csr_di_i[10:0];
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do_o <= '0;
		end else begin
			csr_do_o <= '0;
			if (csr_hit) begin
				case (csr_a_i[3:0])
					tmu_pkg::REG_CTL:      csr_do_o <= {30'd0, cfg_o.chroma_en, busy};
					tmu_pkg::REG_BRIGHT:   csr_do_o <= 32'(cfg_o.brightness);
					tmu_pkg::REG_CKEY:     csr_do_o <= 32'(cfg_o.chroma_key);
					tmu_pkg::REG_TEXFB:    csr_do_o <= 32'(cfg_o.tex_fbuf);
					tmu_pkg::REG_TEXHRES:  csr_do_o <= 32'(cfg_o.tex_hres);
					tmu_pkg::REG_TEXVRES:  csr_do_o <= 32'(cfg_o.tex_vres);
					tmu_pkg::REG_TEXHMASK: csr_do_o <= 32'(cfg_o.tex_hmask);
					tmu_pkg::REG_TEXVMASK: csr_do_o <= 32'(cfg_o.tex_vmask);
					tmu_pkg::REG_DSTFB:    csr_do_o <= 32'(cfg_o.dst_fbuf);
					tmu_pkg::REG_DSTHRES:  csr_do_o <= 32'(cfg_o.dst_hres);
					tmu_pkg::REG_DSTVRES:  csr_do_o <= 32'(cfg_o.dst_vres);
					default:               csr_do_o <= '0;
				endcase
			end
		end
	end

	// ************************************************************
	// job FSM
	// ************************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= tmu_pkg::ST_IDLE;
			irq_o <= 1'b0;
		end else begin
			irq_o <= 1'b0;
			case (state)
				tmu_pkg::ST_IDLE: if (start) state <= tmu_pkg::ST_RUN;
				tmu_pkg::ST_RUN: if (last_i) state <= tmu_pkg::ST_WAIT_DRAIN;
				tmu_pkg::ST_WAIT_DRAIN: if (~pipe_busy) state <= tmu_pkg::ST_FLUSH_DRAIN;
				default: begin
					if (~|busy_i) begin               // flushed word written out
						state <= tmu_pkg::ST_IDLE;
						irq_o <= 1'b1;
					end
				end
			endcase
		end
	end

	// once flushed only burst and pixout may still hold data
	flush_quiet: assert property (@(posedge sys_clk) disable iff (sys_rst)
		state == tmu_pkg::ST_FLUSH_DRAIN |-> busy_i[2:0] == 3'b000);

endmodule

// File: src/tmu_decay.sv
// brightness scaling and chroma key
`timescale 1ns/100ps

module tmu_decay (
	input  logic sys_clk,
	input  logic sys_rst,
	input  tmu_pkg::tmu_cfg_t cfg_i,
	output logic busy_o,
	input  logic pipe_stb_i,
	output logic pipe_ack_o,
	input  tmu_pkg::dpix_t pipe_i,
	output logic pipe_stb_o,
	input  logic pipe_ack_i,
	output tmu_pkg::dpix_t pipe_o
);

	logic [6:0] gain;
	logic [11:0] r_p;
	logic [12:0] g_p;
	logic [11:0] b_p;
	logic keyed;
	logic accept;

	assign gain = {1'b0, cfg_i.brightness} + 7'd1;   // 1..64
	assign r_p = pipe_i.pix.rgb.r * gain;
	assign g_p = pipe_i.pix.rgb.g * gain;
	assign b_p = pipe_i.pix.rgb.b * gain;
	assign keyed = cfg_i.chroma_en & (pipe_i.pix.raw == cfg_i.chroma_key);

	assign pipe_ack_o = ~pipe_stb_o | pipe_ack_i;
	assign accept = pipe_stb_i & pipe_ack_o;
	assign busy_o = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (accept)
			pipe_stb_o <= ~keyed;               // keyed texel vanishes here
		else if (pipe_ack_i)
			pipe_stb_o <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			pipe_o.pix.rgb.r <= r_p[10:6];
			pipe_o.pix.rgb.g <= g_p[11:6];
			pipe_o.pix.rgb.b <= b_p[10:6];
			pipe_o.dst_adr <= pipe_i.dst_adr;
		end
	end

endmodule

// File: src/tmu_geom.sv
// texture coordinate mask, clamp and screen filter
`timescale 1ns/100ps

module tmu_geom (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic run_i,
	input  tmu_pkg::tmu_cfg_t cfg_i,
	input  logic point_stb_i,
	output logic point_ack_o,
	input  tmu_pkg::point_t point_i,
	output logic last_o,
	output logic busy_o,
	output logic pipe_stb_o,
	input  logic pipe_ack_i,
	output tmu_pkg::texreq_t pipe_o
);

	tmu_pkg::fixp_t tx_m;
	tmu_pkg::fixp_t ty_m;
	logic on_screen;
	logic accept;
	logic [tmu_pkg::FML_DEPTH-2:0] dst_adr;

	// negative to 0, integer part past the edge to res-1
	function automatic logic [10:0] clamp_coord(tmu_pkg::fixp_t c, logic [10:0] res);
		logic [10:0] ipart;
		ipart = c[16:6];
		if (c[17])
			return 11'd0;
		else if (ipart >= res)
			return res - 11'd1;
		else
			return ipart;
	endfunction

	assign tx_m = point_i.tx & cfg_i.tex_hmask;
	assign ty_m = point_i.ty & cfg_i.tex_vmask;

	assign on_screen = ~point_i.dx[11] & ~point_i.dy[11]
		& (point_i.dx[10:0] < cfg_i.dst_hres)
		& (point_i.dy[10:0] < cfg_i.dst_vres);

	assign dst_adr = cfg_i.dst_fbuf + point_i.dy[10:0] * cfg_i.dst_hres
		+ point_i.dx[10:0];

	assign point_ack_o = run_i & (~pipe_stb_o | pipe_ack_i);
	assign accept = point_stb_i & point_ack_o;
	assign last_o = accept & point_i.last;   // dropped points count too
	assign busy_o = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pipe_stb_o <= 1'b0;
		end else if (accept) begin
			pipe_stb_o <= on_screen;
		end else if (pipe_ack_i) begin
			pipe_stb_o <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			pipe_o.tx <= clamp_coord(tx_m, cfg_i.tex_hres);
			pipe_o.ty <= clamp_coord(ty_m, cfg_i.tex_vres);
			pipe_o.dst_adr <= dst_adr;
			pipe_o.last <= point_i.last;
		end
	end

endmodule

// File: src/tmu_lite.sv
// texture mapping unit back end
`timescale 1ns/100ps

module tmu_lite (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic [13:0] csr_a_i,
	input  logic csr_we_i,
	input  logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,
	output logic irq_o,
	input  logic point_stb_i,
	output logic point_ack_o,
	input  tmu_pkg::point_t point_i,
	output logic [tmu_pkg::FML_DEPTH-1:0] fmlr_adr_o,
	output logic fmlr_stb_o,
	input  logic fmlr_ack_i,
	input  logic [63:0] fmlr_di_i,
	output logic [tmu_pkg::FML_DEPTH-1:0] fmlw_adr_o,
	output logic fmlw_stb_o,
	output logic [7:0] fmlw_sel_o,
	output logic [63:0] fmlw_do_o,
	input  logic fmlw_ack_i
);

	tmu_pkg::tmu_cfg_t cfg;
	logic run, flush, last;
	logic [4:0] busy;                        // pixout, burst, decay, texfetch, geom

	logic geom_stb, geom_ack;
	tmu_pkg::texreq_t geom_q;
	logic fetch_stb, fetch_ack;
	tmu_pkg::dpix_t fetch_q;
	logic decay_stb, decay_ack;
	tmu_pkg::dpix_t decay_q;
	logic burst_stb, burst_ack;
	tmu_pkg::wword_t burst_q;

	tmu_ctlif ctlif (.sys_clk, .sys_rst, .csr_a_i, .csr_we_i, .csr_di_i, .csr_do_o,
		.irq_o, .run_o(run), .cfg_o(cfg), .flush_o(flush), .last_i(last),
		.busy_i(busy));

	tmu_geom geom (.sys_clk, .sys_rst, .run_i(run), .cfg_i(cfg), .point_stb_i,
		.point_ack_o, .point_i, .last_o(last), .busy_o(busy[0]),
		.pipe_stb_o(geom_stb), .pipe_ack_i(geom_ack), .pipe_o(geom_q));

	tmu_texfetch texfetch (.sys_clk, .sys_rst, .cfg_i(cfg), .busy_o(busy[1]),
		.pipe_stb_i(geom_stb), .pipe_ack_o(geom_ack), .pipe_i(geom_q),
		.fmlr_adr_o, .fmlr_stb_o, .fmlr_ack_i, .fmlr_di_i,
		.pipe_stb_o(fetch_stb), .pipe_ack_i(fetch_ack), .pipe_o(fetch_q));

	tmu_decay decay (.sys_clk, .sys_rst, .cfg_i(cfg), .busy_o(busy[2]),
		.pipe_stb_i(fetch_stb), .pipe_ack_o(fetch_ack), .pipe_i(fetch_q),
		.pipe_stb_o(decay_stb), .pipe_ack_i(decay_ack), .pipe_o(decay_q));

	tmu_burst burst (.sys_clk, .sys_rst, .flush_i(flush), .busy_o(busy[3]),
		.pipe_stb_i(decay_stb), .pipe_ack_o(decay_ack), .pipe_i(decay_q),
		.pipe_stb_o(burst_stb), .pipe_ack_i(burst_ack), .pipe_o(burst_q));

	tmu_pixout pixout (.sys_clk, .sys_rst, .busy_o(busy[4]),
		.pipe_stb_i(burst_stb), .pipe_ack_o(burst_ack), .pipe_i(burst_q),
		.fmlw_adr_o, .fmlw_stb_o, .fmlw_sel_o, .fmlw_do_o, .fmlw_ack_i);

endmodule

// File: src/tmu_pixout.sv
// memory write port master
`timescale 1ns/100ps

module tmu_pixout (
	input  logic sys_clk,
	input  logic sys_rst,
	output logic busy_o,
	input  logic pipe_stb_i,
	output logic pipe_ack_o,
	input  tmu_pkg::wword_t pipe_i,
	output logic [tmu_pkg::FML_DEPTH-1:0] fmlw_adr_o,
	output logic fmlw_stb_o,
	output logic [7:0] fmlw_sel_o,
	output logic [63:0] fmlw_do_o,
	input  logic fmlw_ack_i
);

	tmu_pkg::wword_t word;

	assign pipe_ack_o = ~fmlw_stb_o;          // only when empty
	assign busy_o = fmlw_stb_o;
	assign fmlw_adr_o = {word.adr, 3'b000};
	assign fmlw_sel_o = word.sel;
	assign fmlw_do_o = word.data;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			fmlw_stb_o <= 1'b0;
		else if (pipe_stb_i & pipe_ack_o)
			fmlw_stb_o <= 1'b1;
		else if (fmlw_ack_i)
			fmlw_stb_o <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i & pipe_ack_o)
			word <= pipe_i;
	end

	write_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlw_stb_o && !fmlw_ack_i |=> fmlw_stb_o
			&& $stable({fmlw_adr_o, fmlw_sel_o, fmlw_do_o}));

endmodule

// File: src/tmu_pkg.sv
// texture mapping unit definitions
package tmu_pkg;

	localparam int FML_DEPTH = 20;           // memory byte address width
	localparam logic [3:0] CSR_SEL = 4'd0;   // csr_a[13:10] match

	// register index, csr_a[3:0]
	localparam logic [3:0] REG_CTL      = 4'd0;
	localparam logic [3:0] REG_BRIGHT   = 4'd1;
	localparam logic [3:0] REG_CKEY     = 4'd2;
	localparam logic [3:0] REG_TEXFB    = 4'd3;
	localparam logic [3:0] REG_TEXHRES  = 4'd4;
	localparam logic [3:0] REG_TEXVRES  = 4'd5;
	localparam logic [3:0] REG_TEXHMASK = 4'd6;
	localparam logic [3:0] REG_TEXVMASK = 4'd7;
	localparam logic [3:0] REG_DSTFB    = 4'd8;
	localparam logic [3:0] REG_DSTHRES  = 4'd9;
	localparam logic [3:0] REG_DSTVRES  = 4'd10;

	// job states
	localparam logic [1:0] ST_IDLE        = 2'd0;
	localparam logic [1:0] ST_RUN         = 2'd1;
	localparam logic [1:0] ST_WAIT_DRAIN  = 2'd2;
	localparam logic [1:0] ST_FLUSH_DRAIN = 2'd3;

	// busy order {pixout, burst, decay, texfetch, geom}
	// burst holds its open word until flushed, so the first drain skips it
	localparam logic [4:0] BUSY_PIPE = 5'b10111;

	typedef logic signed [17:0] fixp_t;      // s11.6

	typedef struct packed {
		logic signed [11:0] dx;
		logic signed [11:0] dy;
		fixp_t tx;
		fixp_t ty;
		logic last;
	} point_t;

	typedef struct packed {
		logic chroma_en;
		logic [5:0] brightness;
		logic [15:0] chroma_key;
		logic [FML_DEPTH-2:0] tex_fbuf;      // 16-bit words
		logic [10:0] tex_hres;
		logic [10:0] tex_vres;
		logic [17:0] tex_hmask;
		logic [17:0] tex_vmask;
		logic [FML_DEPTH-2:0] dst_fbuf;      // 16-bit words
		logic [10:0] dst_hres;
		logic [10:0] dst_vres;
	} tmu_cfg_t;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	typedef union packed {
		logic [15:0] raw;                    // chroma key compare
		rgb565_t rgb;                        // brightness scaling
	} pixel_u;

	typedef struct packed {
		logic [10:0] tx;                     // clamped texel column
		logic [10:0] ty;                     // clamped texel row
		logic [FML_DEPTH-2:0] dst_adr;
		logic last;
	} texreq_t;

	typedef struct packed {
		pixel_u pix;
		logic [FML_DEPTH-2:0] dst_adr;
	} dpix_t;

	typedef struct packed {
		logic [FML_DEPTH-4:0] adr;           // 64-bit word address
		logic [7:0] sel;
		logic [63:0] data;
	} wword_t;

endpackage

// File: src/tmu_texfetch.sv
// texel fetch over the memory read port
`timescale 1ns/100ps

module tmu_texfetch (
	input  logic sys_clk,
	input  logic sys_rst,
	input  tmu_pkg::tmu_cfg_t cfg_i,
	output logic busy_o,
	input  logic pipe_stb_i,
	output logic pipe_ack_o,
	input  tmu_pkg::texreq_t pipe_i,
	output logic [tmu_pkg::FML_DEPTH-1:0] fmlr_adr_o,
	output logic fmlr_stb_o,
	input  logic fmlr_ack_i,
	input  logic [63:0] fmlr_di_i,
	output logic pipe_stb_o,
	input  logic pipe_ack_i,
	output tmu_pkg::dpix_t pipe_o
);

	tmu_pkg::texreq_t req;
	tmu_pkg::pixel_u texel;
	logic [tmu_pkg::FML_DEPTH-2:0] tex_adr;
	logic [1:0] lane;

	assign tex_adr = cfg_i.tex_fbuf + req.ty * cfg_i.tex_hres + req.tx;
	assign fmlr_adr_o = {tex_adr[tmu_pkg::FML_DEPTH-2:2], 3'b000};
	assign lane = 2'd3 - tex_adr[1:0];        // word 00 sits in the top lane

	assign busy_o = fmlr_stb_o | pipe_stb_o;
	assign pipe_ack_o = ~busy_o;              // one read in flight
	assign pipe_o.pix = texel;
	assign pipe_o.dst_adr = req.dst_adr;

	// ************************************************************
	// request, read, present
	// ************************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			fmlr_stb_o <= 1'b0;
			pipe_stb_o <= 1'b0;
		end else begin
			if (pipe_stb_i & pipe_ack_o)
				fmlr_stb_o <= 1'b1;
			else if (fmlr_ack_i)
				fmlr_stb_o <= 1'b0;
			if (fmlr_stb_o & fmlr_ack_i)
				pipe_stb_o <= 1'b1;
			else if (pipe_ack_i)
				pipe_stb_o <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i & pipe_ack_o)
			req <= pipe_i;
		if (fmlr_stb_o & fmlr_ack_i)
			texel.raw <= fmlr_di_i[lane*16 +: 16];
	end

	read_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fmlr_stb_o && !fmlr_ack_i |=> fmlr_stb_o && $stable(fmlr_adr_o));

endmodule

// File: tmu_lite.f
+incdir+dv
src/tmu_pkg.sv
src/tmu_ctlif.sv
src/tmu_geom.sv
src/tmu_texfetch.sv
src/tmu_decay.sv
src/tmu_burst.sv
src/tmu_pixout.sv
src/tmu_lite.sv
dv/tmu_tb.sv
